/* Makefile */
SRCS := $(shell cat build.f)

.PHONY: all run clean

all: obj_dir/Vtb_udp_rx

obj_dir/Vtb_udp_rx: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module tb_udp_rx

run: obj_dir/Vtb_udp_rx
	@out="$$(./obj_dir/Vtb_udp_rx)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

/* build.f */
udp_rx_pkg.sv
udp_rx_fifo.sv
udp_rx_header_match.sv
udp_rx_frame_fsm.sv
udp_rx_app_writer.sv
udp_rx_top.sv
tb_udp_rx.sv

/* tb_udp_rx.sv */
`timescale 1ns/1ps
module tb_udp_rx
  import udp_rx_pkg::*;
();

  localparam logic [47:0] LOCAL_MAC  = 48'h02_12_34_56_78_9a;
  localparam logic [31:0] LOCAL_IP   = 32'hc0a8010a;
  localparam logic [15:0] LOCAL_PORT = 16'd5000;
  localparam logic [31:0] GROUP_IP   = 32'hef010200;
  localparam logic [31:0] GROUP_MASK = 32'hffffff00;
  localparam logic [15:0] ETH_IPV4   = 16'h0800;
  localparam logic [7:0]  PROTO_UDP  = 8'h11;

  // one word as the application sees it
  typedef struct packed {
    logic [63:0] data;
    logic        eof;
    logic        bad;
    logic        overrun;
    logic [31:0] ip;
    logic [15:0] port;
  } rx_word_t;

  logic        mac_clk;
  logic        mac_rst;
  mac_beat_t   mac_rx;
  logic        phy_rx_up;
  local_cfg_t  cfg;
  logic        app_rx_ack;
  logic        app_rx_overrun_ack;
  logic        app_rx_valid;
  logic [63:0] app_rx_data;
  logic        app_rx_end_of_frame;
  logic        app_rx_bad_frame;
  logic        app_rx_overrun;
  logic [31:0] app_rx_source_ip;
  logic [15:0] app_rx_source_port;

  rx_word_t exp_q[$];
  int       seed = 38;
  int       errors = 0;
  int       tests_passed = 0;
  int       tests_failed = 0;

  udp_rx_top uut (
    .mac_clk, .mac_rst, .mac_rx, .phy_rx_up, .cfg, .app_rx_ack, .app_rx_overrun_ack,
    .app_rx_valid, .app_rx_data, .app_rx_end_of_frame, .app_rx_bad_frame,
    .app_rx_overrun, .app_rx_source_ip, .app_rx_source_port
  );

  initial begin
    mac_clk = 1'b0;
    forever #50 mac_clk = ~mac_clk;
  end

  // keep = number of words expected out, a cut frame ends in an overrun word
  task automatic send_frame(input logic [47:0] dst_mac, input logic [15:0] ether_type,
                            input logic [7:0] proto, input logic [31:0] dst_ip,
                            input logic [15:0] dst_port, input int nwords,
                            input int keep, input logic bad_end);
    logic [7:0]  fb[];
    logic [31:0] src_ip;
    logic [15:0] src_port;
    rx_word_t    w;
    int          nbeats;
    int          i;
    int          k;
    nbeats = nwords + 6;
    fb = new[nbeats * 8];
    for (i = 0; i < nbeats * 8; i++)
      fb[i] = 8'($random(seed));
    src_ip = $random(seed);
    src_port = 16'($random(seed));
    for (i = 0; i < 6; i++)
      fb[i] = dst_mac[47 - 8*i -: 8];
    fb[12] = ether_type[15:8];
    fb[13] = ether_type[7:0];
    fb[14] = 8'h45;
    fb[23] = proto;
    for (i = 0; i < 4; i++) begin
      fb[26 + i] = src_ip[31 - 8*i -: 8];
      fb[30 + i] = dst_ip[31 - 8*i -: 8];
    end
    fb[34] = src_port[15:8];
    fb[35] = src_port[7:0];
    fb[36] = dst_port[15:8];
    fb[37] = dst_port[7:0];
    // udp payload starts at byte 42, first byte in the top lane
    for (k = 0; k < keep; k++) begin
      for (i = 0; i < 8; i++)
        w.data[63 - 8*i -: 8] = fb[42 + 8*k + i];
      w.eof = (k == keep - 1);
      w.overrun = w.eof && (keep < nwords);
      w.bad = w.eof && bad_end && (keep == nwords);
      w.ip = src_ip;
      w.port = src_port;
      exp_q.push_back(w);
    end
    for (i = 0; i < nbeats; i++) begin
      @(posedge mac_clk);
      #1;
      for (k = 0; k < 8; k++)
        mac_rx.data[8*k +: 8] = fb[8*i + k];
      mac_rx.valid = 8'hff;
      mac_rx.good = (i == nbeats - 1) && !bad_end;
      mac_rx.bad = (i == nbeats - 1) && bad_end;
    end
    @(posedge mac_clk);
    #1;
    mac_rx = '0;
    repeat (4) @(posedge mac_clk);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 2000) begin
      @(posedge mac_clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d expected words were never delivered", exp_q.size());
      errors++;
    end
    // quiet window, stray words show up here
    repeat (10) @(posedge mac_clk);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (errors == errs_at_start) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - errs_at_start);
      tests_failed++;
    end
  endtask

  // words are sampled at the falling edge, before the consuming rising edge
  always @(negedge mac_clk) begin : check_word
    rx_word_t got;
    rx_word_t exp;
    if (!mac_rst && app_rx_valid && app_rx_ack) begin
      got.data = app_rx_data;
      got.eof = app_rx_end_of_frame;
      got.bad = app_rx_bad_frame;
      got.overrun = app_rx_overrun;
      got.ip = app_rx_source_ip;
      got.port = app_rx_source_port;
      assert (exp_q.size() != 0) else begin
        $display("error %0t: unexpected word %h delivered", $time, got.data);
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        assert (got == exp) else begin
          $display("error %0t: got data %h eof %b bad %b ovr %b src %h:%h", $time,
                   got.data, got.eof, got.bad, got.overrun, got.ip, got.port);
          $display("error %0t: expected data %h eof %b bad %b ovr %b src %h:%h", $time,
                   exp.data, exp.eof, exp.bad, exp.overrun, exp.ip, exp.port);
          errors++;
        end
      end
    end
  end

  a_overrun_ends_frame: assert property (@(posedge mac_clk) disable iff (mac_rst)
    app_rx_valid && app_rx_overrun |-> app_rx_end_of_frame)
    else begin
      $display("error %0t: overrun word without end of frame", $time);
      errors++;
    end
  a_bad_ends_frame: assert property (@(posedge mac_clk) disable iff (mac_rst)
    app_rx_valid && app_rx_bad_frame |-> app_rx_end_of_frame)
    else begin
      $display("error %0t: bad frame flag without end of frame", $time);
      errors++;
    end

  initial begin
    int errs;
    int n;
    mac_rst = 1'b1;
    mac_rx = '0;
    phy_rx_up = 1'b1;
    cfg = '{enable: 1'b1, mac: LOCAL_MAC, ip: LOCAL_IP, port: LOCAL_PORT,
            mc_ip: GROUP_IP, mc_mask: GROUP_MASK};
    app_rx_ack = 1'b1;
    app_rx_overrun_ack = 1'b0;
    repeat (5) @(posedge mac_clk);
    #1 mac_rst = 1'b0;
    repeat (3) @(posedge mac_clk);

    errs = errors;
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 5, 5, 1'b0);
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 1, 1, 1'b0);
    wait_drain();
    report_test("unicast frame", errs);

    errs = errors;
    send_frame(48'h02_00_00_00_00_99, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 3, 0, 1'b0);
    send_frame(LOCAL_MAC, 16'h86dd, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 3, 0, 1'b0);
    send_frame(LOCAL_MAC, ETH_IPV4, 8'h06, LOCAL_IP, LOCAL_PORT, 3, 0, 1'b0);
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, 16'd5001, 3, 0, 1'b0);
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, 32'hc0a80163, LOCAL_PORT, 3, 0, 1'b0);
    wait_drain();
    report_test("rejected fields", errs);

    errs = errors;
    send_frame(48'hff_ff_ff_ff_ff_ff, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 4, 4, 1'b0);
    send_frame(48'h01_00_5e_01_02_37, ETH_IPV4, PROTO_UDP, 32'hef010237, LOCAL_PORT,
               4, 4, 1'b0);
    wait_drain();
    report_test("broadcast and multicast", errs);

    errs = errors;
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 3, 3, 1'b1);
    wait_drain();
    report_test("bad frame end", errs);

    errs = errors;
    #1 cfg.enable = 1'b0;
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 3, 0, 1'b0);
    #1 cfg.enable = 1'b1;
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 3, 3, 1'b0);
    #1 phy_rx_up = 1'b0;
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 3, 0, 1'b0);
    #1 phy_rx_up = 1'b1;
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 3, 3, 1'b0);
    wait_drain();
    report_test("enable and phy gating", errs);

    // 7 frames of 8 words reach the almost full mark, the 8th is cut at once
    errs = errors;
    #1 app_rx_ack = 1'b0;
    for (n = 0; n < 7; n++)
      send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 8, 8, 1'b0);
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 8, 1, 1'b0);
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 8, 0, 1'b0);
    #1 app_rx_ack = 1'b1;
    wait_drain();
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 4, 0, 1'b0);
    wait_drain();
    #1 app_rx_overrun_ack = 1'b1;
    repeat (3) @(posedge mac_clk);
    #1 app_rx_overrun_ack = 1'b0;
    send_frame(LOCAL_MAC, ETH_IPV4, PROTO_UDP, LOCAL_IP, LOCAL_PORT, 8, 8, 1'b0);
    wait_drain();
    report_test("overrun", errs);

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* udp_rx_app_writer.sv */
`timescale 1ns/1ps
module udp_rx_app_writer
  import udp_rx_pkg::*;
(
  input  logic        mac_clk,
  input  logic        mac_rst,
  input  logic        payload_valid,
  input  logic [63:0] payload,
  input  src_info_t   src_info,
  input  logic        first_word,
  input  logic        frame_good,
  input  logic        frame_bad,
  input  logic        pkt_almost_full,
  input  logic        ctrl_almost_full,
  input  logic        overrun_ack,
  output logic        pkt_wr_en,
  output app_word_t   pkt_wr_data,
  output logic        ctrl_wr_en,
  output src_info_t   ctrl_wr_data
);

  app_state_e state;
  logic       frame_live;
  logic       fifo_af;
  logic       wr_word;
  logic       cut;
  logic       word_eof;

  assign fifo_af = pkt_almost_full || ctrl_almost_full;

  // a frame is only written if its first word went in during run
  assign wr_word  = payload_valid && state == APP_RUN && (first_word || frame_live);
  assign cut      = wr_word && fifo_af;
  assign word_eof = frame_good || frame_bad || cut;

  assign pkt_wr_en   = wr_word;
  assign pkt_wr_data = '{overrun: cut, bad: frame_bad, eof: word_eof, data: payload};

  // source info goes in once per frame with its first word
  assign ctrl_wr_en   = wr_word && first_word;
  assign ctrl_wr_data = src_info;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state      <= APP_RUN;
      frame_live <= 1'b0;
    end else begin
      if (wr_word) begin
        frame_live <= !word_eof;
      end else if (frame_good || frame_bad) begin
        frame_live <= 1'b0;
      end
      case (state)
        APP_RUN: if (cut) state <= APP_OVER;
        // wait for the application to raise then drop its ack
        APP_OVER: if (overrun_ack) state <= APP_WAIT;
        APP_WAIT: if (!overrun_ack) state <= APP_RUN;
        default: state <= APP_RUN;
      endcase
    end
  end

  // writing stops right after the word that carries the overrun cut
  a_no_write_in_overrun: assert property (@(posedge mac_clk) disable iff (mac_rst)
    cut |=> !pkt_wr_en && !ctrl_wr_en);

endmodule

/* udp_rx_fifo.sv */
`timescale 1ns/1ps
module udp_rx_fifo #(
  parameter int WIDTH       = 64,
  parameter int DEPTH       = 64,
  parameter int ALMOST_FULL = DEPTH - 8
) (
  input  logic             mac_clk,
  input  logic             mac_rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             almost_full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    ptr_next = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = count == (AW+1)'(DEPTH);
  assign empty       = count == '0;
  assign almost_full = count >= (AW+1)'(ALMOST_FULL);
  assign push        = wr_en && !full;
  assign pop         = rd_en && !empty;

  // first word falls through, head is always on the read port
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (push) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop) rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_write_full: assert property (@(posedge mac_clk) disable iff (mac_rst)
    wr_en |-> !full);
  a_no_read_empty: assert property (@(posedge mac_clk) disable iff (mac_rst)
    rd_en |-> !empty);

endmodule

/* udp_rx_frame_fsm.sv */
`timescale 1ns/1ps
module udp_rx_frame_fsm
  import udp_rx_pkg::*;
(
  input  logic         mac_clk,
  input  logic         mac_rst,
  input  mac_beat_t    beat_z,
  input  mac_beat_t    beat_r,
  input  match_flags_t flags,
  input  logic         phy_rx_up,
  input  logic         enable,
  output logic         frame_accept,
  output logic         payload_valid,
  output logic [63:0]  payload,
  output src_info_t    src_info,
  output logic         first_word
);

  rx_state_e state;
  logic      first_pending;
  logic      end_z;
  logic      end_r;

  assign end_z = beat_z.good || beat_z.bad;
  assign end_r = beat_r.good || beat_r.bad;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state         <= RX_IDLE;
      frame_accept  <= 1'b0;
      first_pending <= 1'b0;
    end else begin
      case (state)
        RX_IDLE: begin
          frame_accept <= 1'b0;
          if (beat_z.valid == 8'hff && phy_rx_up) begin
            frame_accept <= flags.mac_ok;
            state        <= flags.mac_ok ? RX_WORD_2 : RX_DROP;
          end
        end
        RX_WORD_2: begin
          frame_accept <= flags.ipv4_ok;
          state        <= flags.ipv4_ok ? RX_WORD_3 : RX_DROP;
        end
        RX_WORD_3: begin
          frame_accept <= flags.udp_ok;
          state        <= flags.udp_ok ? RX_WORD_4 : RX_DROP;
        end
        RX_WORD_4: state <= RX_WORD_5;
        RX_WORD_5: begin
          frame_accept <= flags.ip_ok && flags.port_ok;
          state        <= (flags.ip_ok && flags.port_ok) ? RX_WORD_6 : RX_DROP;
        end
        RX_WORD_6: begin
          first_pending <= 1'b1;
          state         <= RX_DATA;
        end
        RX_DATA: begin
          if (payload_valid) first_pending <= 1'b0;
          if (end_r) begin
            frame_accept <= 1'b0;
            state        <= RX_IDLE;
          end
        end
        RX_DROP: if (end_r) state <= RX_IDLE;
        default: state <= RX_IDLE;
      endcase
      // runt frame that ends inside the header
      if (state inside {RX_WORD_2, RX_WORD_3, RX_WORD_4, RX_WORD_5} && end_z) begin
        frame_accept <= 1'b0;
        state        <= RX_DROP;
      end
      if (!enable) frame_accept <= 1'b0;
    end
  end

  // source address fields byte swapped into host order
  always_ff @(posedge mac_clk) begin
    if (state == RX_WORD_4) begin
      src_info.ip <= {beat_z.data[23:16], beat_z.data[31:24],
                      beat_z.data[39:32], beat_z.data[47:40]};
    end
    if (state == RX_WORD_5) src_info.port <= {beat_z.data[23:16], beat_z.data[31:24]};
  end

  assign payload_valid = frame_accept && state == RX_DATA && !end_r;
  assign first_word    = payload_valid && first_pending;

  // bytes 42+8k to 49+8k with the first byte in the top lane
  assign payload = {beat_r.data[23:16], beat_r.data[31:24], beat_r.data[39:32],
                    beat_r.data[47:40], beat_r.data[55:48], beat_r.data[63:56],
                    beat_z.data[7:0], beat_z.data[15:8]};

  a_state_known: assert property (@(posedge mac_clk) disable iff (mac_rst)
    !$isunknown(state));
  // acceptance is settled in the header and never rises during payload
  a_valid_accepted: assert property (@(posedge mac_clk) disable iff (mac_rst)
    payload_valid |-> $past(frame_accept));

endmodule

/* udp_rx_header_match.sv */
`timescale 1ns/1ps
module udp_rx_header_match
  import udp_rx_pkg::*;
(
  input  logic         mac_clk,
  input  logic         mac_rst,
  input  mac_beat_t    mac_rx,
  input  local_cfg_t   cfg,
  output mac_beat_t    beat_z,
  output mac_beat_t    beat_r,
  output match_flags_t flags
);

  logic [47:0] dst_mac;
  logic [15:0] ether_type;
  logic [7:0]  ver_ihl;
  logic [7:0]  protocol;
  logic [31:0] dst_ip;
  logic [15:0] dst_port;

  // two register stages, beat_r holds the previous beat
  always_ff @(posedge mac_clk) begin
    beat_z <= mac_rx;
    beat_r <= beat_z;
    if (mac_rst) begin
      beat_z.valid <= '0;
      beat_z.good  <= 1'b0;
      beat_z.bad   <= 1'b0;
      beat_r.valid <= '0;
      beat_r.good  <= 1'b0;
      beat_r.bad   <= 1'b0;
    end
  end

  // byte 0 of the wire sits in data[7:0], fields are big endian
  assign dst_mac = {beat_z.data[7:0], beat_z.data[15:8], beat_z.data[23:16],
                    beat_z.data[31:24], beat_z.data[39:32], beat_z.data[47:40]};

  // word 1 carries ethertype and the version byte
  assign ether_type = {beat_z.data[39:32], beat_z.data[47:40]};
  assign ver_ihl    = beat_z.data[55:48];

  // word 2, last byte is the IP protocol
  assign protocol = beat_z.data[63:56];

  // destination IP straddles words 3 and 4
  assign dst_ip = {beat_r.data[55:48], beat_r.data[63:56],
                   beat_z.data[7:0], beat_z.data[15:8]};

  assign dst_port = {beat_z.data[39:32], beat_z.data[47:40]};

  always_comb begin
    flags.mac_ok  = (dst_mac == cfg.mac) || (dst_mac == '1) ||
                    (dst_mac[47:24] == MC_MAC_PREFIX);
    flags.ipv4_ok = (ether_type == ETHERTYPE_IPV4) && (ver_ihl == IPV4_VER_IHL);
    flags.udp_ok  = protocol == IP_PROTO_UDP;
    // own address, the multicast group, or anything inside the group mask
    flags.ip_ok   = (dst_ip == cfg.ip) || (dst_ip == cfg.mc_ip) ||
                    ((dst_ip & cfg.mc_mask) == (cfg.mc_ip & cfg.mc_mask));
    flags.port_ok = dst_port == cfg.port;
  end

endmodule

/* udp_rx_pkg.sv */
package udp_rx_pkg;

  // one beat from the 10G MAC receive side
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  valid;
    logic        good;
    logic        bad;
  } mac_beat_t;

  typedef struct packed {
    logic        enable;
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
    logic [31:0] mc_ip;
    logic [31:0] mc_mask;
  } local_cfg_t;

  typedef struct packed {
    logic mac_ok;
    logic ipv4_ok;
    logic udp_ok;
    logic ip_ok;
    logic port_ok;
  } match_flags_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_WORD_2,
    RX_WORD_3,
    RX_WORD_4,
    RX_WORD_5,
    RX_WORD_6,
    RX_DATA,
    RX_DROP
  } rx_state_e;

  // packet fifo entry, flags above the payload
  typedef struct packed {
    logic        overrun;
    logic        bad;
    logic        eof;
    logic [63:0] data;
  } app_word_t;

  typedef struct packed {
    logic [15:0] port;
    logic [31:0] ip;
  } src_info_t;

  typedef enum logic [1:0] {
    APP_RUN,
    APP_OVER,
    APP_WAIT
  } app_state_e;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IPV4_VER_IHL   = 8'h45;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;
  localparam logic [23:0] MC_MAC_PREFIX  = 24'h01005e;

endpackage

/* udp_rx_top.sv */
`timescale 1ns/1ps
module udp_rx_top
  import udp_rx_pkg::*;
#(
  parameter int FIFO_DEPTH       = 64,
  parameter int FIFO_ALMOST_FULL = FIFO_DEPTH - 8,
  parameter int CTRL_DEPTH       = 16
) (
  input  logic        mac_clk,
  input  logic        mac_rst,
  input  mac_beat_t   mac_rx,
  input  logic        phy_rx_up,
  input  local_cfg_t  cfg,
  input  logic        app_rx_ack,
  input  logic        app_rx_overrun_ack,
  output logic        app_rx_valid,
  output logic [63:0] app_rx_data,
  output logic        app_rx_end_of_frame,
  output logic        app_rx_bad_frame,
  output logic        app_rx_overrun,
  output logic [31:0] app_rx_source_ip,
  output logic [15:0] app_rx_source_port
);

  mac_beat_t    beat_z;
  mac_beat_t    beat_r;
  match_flags_t flags;
  logic         frame_accept;
  logic         payload_valid;
  logic [63:0]  payload;
  src_info_t    src_info;
  logic         first_word;
  logic         frame_good;
  logic         frame_bad;
  logic         pkt_wr_en;
  app_word_t    pkt_wr_data;
  app_word_t    pkt_rd_data;
  logic         pkt_empty;
  logic         pkt_almost_full;
  logic         ctrl_wr_en;
  src_info_t    ctrl_wr_data;
  src_info_t    ctrl_rd_data;
  logic         ctrl_empty;
  logic         ctrl_almost_full;

  udp_rx_header_match u_match (
    .mac_clk, .mac_rst, .mac_rx, .cfg, .beat_z, .beat_r, .flags
  );

  udp_rx_frame_fsm u_fsm (
    .mac_clk, .mac_rst, .beat_z, .beat_r, .flags, .phy_rx_up,
    .enable (cfg.enable),
    .frame_accept, .payload_valid, .payload, .src_info, .first_word
  );

  // frame end flags count only for an accepted frame
  assign frame_good = frame_accept && beat_z.good;
  assign frame_bad  = frame_accept && beat_z.bad;

  udp_rx_app_writer u_writer (
    .mac_clk, .mac_rst, .payload_valid, .payload, .src_info, .first_word,
    .frame_good, .frame_bad, .pkt_almost_full, .ctrl_almost_full,
    .overrun_ack (app_rx_overrun_ack),
    .pkt_wr_en, .pkt_wr_data, .ctrl_wr_en, .ctrl_wr_data
  );

  udp_rx_fifo #(
    .WIDTH ($bits(app_word_t)), .DEPTH (FIFO_DEPTH), .ALMOST_FULL (FIFO_ALMOST_FULL)
  ) u_pkt_fifo (
    .mac_clk, .mac_rst, .wr_en (pkt_wr_en), .wr_data (pkt_wr_data),
    .rd_en (app_rx_ack && app_rx_valid), .rd_data (pkt_rd_data),
    .empty (pkt_empty), .almost_full (pkt_almost_full)
  );

  // ctrl entry is released with the last word of its frame
  udp_rx_fifo #(
    .WIDTH ($bits(src_info_t)), .DEPTH (CTRL_DEPTH), .ALMOST_FULL (CTRL_DEPTH - 2)
  ) u_ctrl_fifo (
    .mac_clk, .mac_rst, .wr_en (ctrl_wr_en), .wr_data (ctrl_wr_data),
    .rd_en (app_rx_ack && app_rx_valid && pkt_rd_data.eof), .rd_data (ctrl_rd_data),
    .empty (ctrl_empty), .almost_full (ctrl_almost_full)
  );

  assign app_rx_valid        = !pkt_empty && !ctrl_empty;
  assign app_rx_data         = pkt_rd_data.data;
  assign app_rx_end_of_frame = pkt_rd_data.eof;
  assign app_rx_bad_frame    = pkt_rd_data.bad;
  assign app_rx_overrun      = pkt_rd_data.overrun;
  assign app_rx_source_ip    = ctrl_rd_data.ip;
  assign app_rx_source_port  = ctrl_rd_data.port;

endmodule
